// File: files.f
design/mcu_link_pkg.sv
design/mcu_bus_fsm.sv
design/mcu_irq_timer.sv
design/mcu_port_latch.sv
design/mcu_link_top.sv
dv/mcu_link_assertions.sv
dv/mcu_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mcu_link_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
RUN_ARGS  = +verilator+error+limit+1000
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/mcu_link_tb.sv
`timescale 1ns/1ns

module mcu_link_tb import mcu_link_pkg::*; ();

    localparam int timeout_cycles = 64;
    localparam int ack_wait_max   = 8;
    // Tests take about 150 cycles, mostly the wait for the service timeout
    localparam int run_limit      = 2 * (timeout_cycles + 8 + 80);

    logic              clk24 = 1'b0;
    logic              rst24;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    logic [word_w-1:0] wb_dat_w;
    logic [word_w-1:0] wb_dat_r;
    logic              wb_ack;
    logic [7:0]        mcu_p0o;
    logic [7:0]        mcu_p2o;
    logic [7:0]        mcu_p0i;
    logic              mcu_intn;

    integer seed;
    int     check_errors;
    int     errors_at_start;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;

    mcu_link_top #(
        .TIMEOUT_CYCLES ( timeout_cycles )
    ) u_mcu_link_top (
        .clk24    ( clk24    ),
        .rst24    ( rst24    ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   ),
        .mcu_p0o  ( mcu_p0o  ),
        .mcu_p2o  ( mcu_p2o  ),
        .mcu_p0i  ( mcu_p0i  ),
        .mcu_intn ( mcu_intn )
    );

    always #4 clk24 = ~clk24;

    // Bit 0 interrupt pending, bit 1 reply complete, bit 2 service timeout
    function automatic logic [word_w-1:0] expected_status(input logic irq, input logic reply,
                                                          input logic tmo);
        return {{(word_w-3){1'b0}}, tmo, reply, irq};
    endfunction

    function automatic int error_total();
        return check_errors + u_mcu_link_top.u_link_assertions.error_count;
    endfunction

    task automatic check_word(input logic [word_w-1:0] got, input logic [word_w-1:0] exp,
                              input string what);
        assert (got === exp) else begin
            $error("CHECK FAILED at %0t ns: %s, got 0x%h, expected 0x%h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            $error("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic random_word(output logic [word_w-1:0] value);
        logic [31:0] raw;
        raw   = $random(seed);
        value = raw[word_w-1:0];
    endtask

    // One Wishbone classic cycle held until ack is seen
    task automatic bus_cycle(input logic we, input logic [addr_w-1:0] adr,
                             input logic [word_w-1:0] wdata, output logic [word_w-1:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(negedge clk24);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk24);
        while (!wb_ack && waited < ack_wait_max) begin
            @(negedge clk24);
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("Bus cycle to address %0d got no acknowledge within %0d cycles",
                     adr, ack_wait_max);
            check_errors++;
        end
        @(negedge clk24);
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
    endtask

    task automatic bus_write(input logic [addr_w-1:0] adr, input logic [word_w-1:0] data);
        logic [word_w-1:0] discard;
        bus_cycle(1'b1, adr, data, discard);
    endtask

    task automatic bus_read(input logic [addr_w-1:0] adr, output logic [word_w-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // MCU model pulls one port 2 bit low for one cycle
    task automatic mcu_strobe(input int bit_idx, input logic [7:0] data);
        @(negedge clk24);
        mcu_p2o = ~(8'h01 << bit_idx);
        mcu_p0o = data;
        @(negedge clk24);
        mcu_p2o = 8'hFF;
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_total() == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", num, name);
        end
        errors_at_start = error_total();
    endtask

    initial begin : stimulus
        logic [word_w-1:0] cmd;
        logic [word_w-1:0] rnd;
        logic [word_w-1:0] rd;
        seed            = 64;
        check_errors    = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        rst24    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        mcu_p0o  = 8'h00;
        mcu_p2o  = 8'hFF;
        repeat (3) @(negedge clk24);
        rst24 = 1'b0;

        check_bit(mcu_intn, 1'b1, "mcu_intn after reset");
        check_word({8'h00, mcu_p0i}, '0, "mcu_p0i after reset");
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b0), "status after reset");
        bus_read(reg_reply, rd);
        check_word(rd, '0, "reply after reset");
        finish_test(1, "reset values");

        random_word(cmd);
        bus_write(reg_cmd, cmd);
        check_bit(mcu_intn, 1'b0, "mcu_intn after command write");
        mcu_strobe(4, 8'h00);
        check_word({8'h00, mcu_p0i}, {8'h00, cmd[15:8]}, "command high byte on port 0");
        mcu_strobe(5, 8'h00);
        check_word({8'h00, mcu_p0i}, {8'h00, cmd[7:0]}, "command low byte on port 0");
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b1, 1'b0, 1'b0), "status with interrupt pending");
        finish_test(2, "command path");

        mcu_strobe(3, 8'h00);
        check_bit(mcu_intn, 1'b1, "mcu_intn after service");
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b0), "status after service");
        finish_test(3, "interrupt service");

        // High byte first since the low byte completes the reply
        random_word(rnd);
        mcu_strobe(7, rnd[15:8]);
        mcu_strobe(6, rnd[7:0]);
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b0, 1'b1, 1'b0), "status with reply complete");
        bus_read(reg_reply, rd);
        check_word(rd, rnd, "reply word");
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b0, 1'b0, 1'b0), "status after reply read");
        finish_test(4, "reply path");

        random_word(cmd);
        bus_write(reg_cmd, cmd);
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b1, 1'b0, 1'b0), "status before service limit");
        // Interrupt left pending past the service limit
        repeat (timeout_cycles + 8) @(negedge clk24);
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b1, 1'b0, 1'b1), "status after service timeout");
        random_word(cmd);
        bus_write(reg_cmd, cmd);
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b1, 1'b0, 1'b0), "status after new command");
        mcu_strobe(3, 8'h00);
        check_bit(mcu_intn, 1'b1, "mcu_intn after late service");
        finish_test(5, "service timeout");

        random_word(rnd);
        mcu_strobe(7, rnd[15:8]);
        mcu_strobe(6, rnd[7:0]);
        bus_read(reg_cmd, rd);
        check_word(rd, '0, "read of write-only command register");
        bus_write(reg_reply, ~rnd);
        bus_read(reg_status, rd);
        check_word(rd, expected_status(1'b0, 1'b1, 1'b0), "status after write to reply");
        bus_read(reg_reply, rd);
        check_word(rd, rnd, "reply after write to read-only register");
        finish_test(6, "bus corner cases");

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < run_limit) begin
            @(posedge clk24);
            cycle_count++;
        end
        $display("Simulation stopped after %0d cycles without finishing the tests", run_limit);
        $display("Test failed");
        $finish;
    end

endmodule

// File: dv/mcu_link_assertions.sv
`timescale 1ns/1ns

module mcu_link_assertions (
    input logic       clk24,
    input logic       rst24,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       cmd_we,
    input logic [7:0] mcu_p2o,
    input logic       mcu_intn
);

    // Assertion failures seen so far
    int error_count = 0;

    // Registered ack comes exactly one cycle after a new strobe
    ack_after_stb: assert property (@(posedge clk24) disable iff (rst24)
        wb_cyc && $rose(wb_stb) |=> wb_ack)
    else begin
        $error("wb_ack did not follow a new strobe by one cycle");
        error_count++;
    end

    ack_needs_stb: assert property (@(posedge clk24) disable iff (rst24)
        wb_ack |-> wb_stb)
    else begin
        $error("wb_ack was high while wb_stb was low");
        error_count++;
    end

    // Only without an MCU acknowledge on port 2 bit 3, which wins
    intn_after_cmd: assert property (@(posedge clk24) disable iff (rst24)
        cmd_we && mcu_p2o[3] |=> !mcu_intn)
    else begin
        $error("mcu_intn did not fall one cycle after a command write");
        error_count++;
    end

    intn_high_after_reset: assert property (@(posedge clk24)
        $fell(rst24) |-> mcu_intn)
    else begin
        $error("mcu_intn was not high when reset ended");
        error_count++;
    end

endmodule

bind mcu_link_top mcu_link_assertions u_link_assertions (
    .clk24    ( clk24    ),
    .rst24    ( rst24    ),
    .wb_cyc   ( wb_cyc   ),
    .wb_stb   ( wb_stb   ),
    .wb_ack   ( wb_ack   ),
    .cmd_we   ( cmd_we   ),
    .mcu_p2o  ( mcu_p2o  ),
    .mcu_intn ( mcu_intn )
);

// File: design/mcu_link_top.sv
`timescale 1ns/1ns

module mcu_link_top import mcu_link_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic              clk24,
    input  logic              rst24,
    // Host Wishbone classic
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [addr_w-1:0] wb_adr,
    input  logic [word_w-1:0] wb_dat_w,
    output logic [word_w-1:0] wb_dat_r,
    output logic              wb_ack,
    // MCU ports
    input  logic [7:0]        mcu_p0o,
    input  logic [7:0]        mcu_p2o,
    output logic [7:0]        mcu_p0i,
    output logic              mcu_intn
);

    logic              cmd_we;
    logic [word_w-1:0] cmd_data;
    logic              reply_rd;
    logic              irq_pending;
    logic              timeout;
    logic              reply_valid;
    logic [word_w-1:0] reply_word;

    mcu_bus_fsm u_bus_fsm (
        .clk24       ( clk24       ),
        .rst24       ( rst24       ),
        .wb_cyc      ( wb_cyc      ),
        .wb_stb      ( wb_stb      ),
        .wb_we       ( wb_we       ),
        .wb_adr      ( wb_adr      ),
        .wb_dat_w    ( wb_dat_w    ),
        .wb_dat_r    ( wb_dat_r    ),
        .wb_ack      ( wb_ack      ),
        .irq_pending ( irq_pending ),
        .timeout     ( timeout     ),
        .reply_valid ( reply_valid ),
        .reply_word  ( reply_word  ),
        .cmd_we      ( cmd_we      ),
        .cmd_data    ( cmd_data    ),
        .reply_rd    ( reply_rd    )
    );

    mcu_irq_timer #(
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES )
    ) u_irq_timer (
        .clk24       ( clk24       ),
        .rst24       ( rst24       ),
        .cmd_we      ( cmd_we      ),
        .mcu_p2o     ( mcu_p2o     ),
        .mcu_intn    ( mcu_intn    ),
        .irq_pending ( irq_pending ),
        .timeout     ( timeout     )
    );

    mcu_port_latch u_port_latch (
        .clk24       ( clk24       ),
        .rst24       ( rst24       ),
        .cmd_we      ( cmd_we      ),
        .cmd_data    ( cmd_data    ),
        .reply_rd    ( reply_rd    ),
        .mcu_p2o     ( mcu_p2o     ),
        .mcu_p0o     ( mcu_p0o     ),
        .mcu_p0i     ( mcu_p0i     ),
        .reply_word  ( reply_word  ),
        .reply_valid ( reply_valid )
    );

endmodule

// File: design/mcu_port_latch.sv
`timescale 1ns/1ns

module mcu_port_latch import mcu_link_pkg::*; (
    input  logic              clk24,
    input  logic              rst24,
    // From the bus side
    input  logic              cmd_we,
    input  logic [word_w-1:0] cmd_data,
    input  logic              reply_rd,
    // MCU ports
    input  logic [7:0]        mcu_p2o,
    input  logic [7:0]        mcu_p0o,
    output logic [7:0]        mcu_p0i,
    // To the bus side
    output logic [word_w-1:0] reply_word,
    output logic              reply_valid
);

    logic [word_w-1:0] cmd_reg;
    logic              rd_hi;
    logic              rd_lo;
    logic              wr_lo;
    logic              wr_hi;

    // Port 2 strobes are all active low
    assign rd_hi = !mcu_p2o[4];
    assign rd_lo = !mcu_p2o[5];
    assign wr_lo = !mcu_p2o[6];
    assign wr_hi = !mcu_p2o[7];

    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            cmd_reg <= '0;
            mcu_p0i <= '0;
        end else begin
            if (cmd_we) begin
                cmd_reg <= cmd_data;
            end
            // Low byte wins if both read strobes are low
            if (rd_lo) begin
                mcu_p0i <= cmd_reg[7:0];
            end else if (rd_hi) begin
                mcu_p0i <= cmd_reg[word_w-1 -: 8];
            end
        end
    end

    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            reply_word <= '0;
        end else begin
            if (wr_hi) begin
                reply_word[word_w-1 -: 8] <= mcu_p0o;
            end
            if (wr_lo) begin
                reply_word[7:0] <= mcu_p0o;
            end
        end
    end

    // Low byte is written last, so it completes the reply
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            reply_valid <= 1'b0;
        end else if (wr_lo) begin
            reply_valid <= 1'b1;
        end else if (reply_rd || cmd_we) begin
            reply_valid <= 1'b0;
        end
    end

endmodule

// File: design/mcu_irq_timer.sv
`timescale 1ns/1ns

module mcu_irq_timer #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic       clk24,
    input  logic       rst24,
    input  logic       cmd_we,
    input  logic [7:0] mcu_p2o,
    output logic       mcu_intn,
    output logic       irq_pending,
    output logic       timeout
);

    localparam int cnt_w = $clog2(TIMEOUT_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_max  = cnt_w'(TIMEOUT_CYCLES);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(TIMEOUT_CYCLES - 1);

    logic             irq_flag;
    logic             irq_clr;
    logic [cnt_w-1:0] cnt;

    // Port 2 bit 3 low is the MCU acknowledge
    assign irq_clr = !mcu_p2o[3];

    assign irq_pending = irq_flag;
    assign mcu_intn    = !irq_flag;

    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            irq_flag <= 1'b0;
        end else if (irq_clr) begin
            // MCU acknowledge beats a simultaneous new command
            irq_flag <= 1'b0;
        end else if (cmd_we) begin
            irq_flag <= 1'b1;
        end
    end

    // Counts cycles since mcu_intn fell and holds at the limit
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            cnt <= '0;
        end else if (cmd_we || !irq_flag) begin
            cnt <= '0;
        end else if (cnt != cnt_max) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Sticky until the host sends the next command
    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            timeout <= 1'b0;
        end else if (cmd_we) begin
            timeout <= 1'b0;
        end else if (irq_flag && cnt == cnt_last) begin
            timeout <= 1'b1;
        end
    end

endmodule

// File: design/mcu_bus_fsm.sv
`timescale 1ns/1ns

module mcu_bus_fsm import mcu_link_pkg::*; (
    input  logic              clk24,
    input  logic              rst24,
    // Wishbone classic slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [addr_w-1:0] wb_adr,
    input  logic [word_w-1:0] wb_dat_w,
    output logic [word_w-1:0] wb_dat_r,
    output logic              wb_ack,
    // Flags and reply from the MCU side
    input  logic              irq_pending,
    input  logic              timeout,
    input  logic              reply_valid,
    input  logic [word_w-1:0] reply_word,
    // Strobes to the MCU side
    output logic              cmd_we,
    output logic [word_w-1:0] cmd_data,
    output logic              reply_rd
);

    typedef enum logic [1:0] {
        st_idle,
        st_ack,
        st_wait
    } state_t;

    state_t            state;
    logic              accept;
    logic              sel_cmd;
    logic              sel_reply;
    logic              sel_status;
    logic [word_w-1:0] status_word;
    logic [word_w-1:0] rd_mux;

    // New cycle only taken from idle
    assign accept = (state == st_idle) && wb_cyc && wb_stb;

    // Address decode shared by the strobes and the read mux
    assign sel_cmd    = (wb_adr == reg_cmd);
    assign sel_reply  = (wb_adr == reg_reply);
    assign sel_status = (wb_adr == reg_status);

    always_comb begin
        status_word               = '0;
        status_word[st_irq_bit]   = irq_pending;
        status_word[st_reply_bit] = reply_valid;
        status_word[st_tmo_bit]   = timeout;
    end

    // Unmapped and write-only addresses read as zero
    always_comb begin
        if (sel_reply) begin
            rd_mux = reply_word;
        end else if (sel_status) begin
            rd_mux = status_word;
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge clk24 or posedge rst24) begin
        if (rst24) begin
            state    <= st_idle;
            wb_ack   <= 1'b0;
            cmd_we   <= 1'b0;
            reply_rd <= 1'b0;
        end else begin
            wb_ack   <= accept;
            cmd_we   <= accept && wb_we && sel_cmd;
            reply_rd <= accept && !wb_we && sel_reply;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    state <= st_wait;
                end
                // Host must drop stb before the next cycle
                st_wait: begin
                    if (!wb_stb) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data captured at accept and valid while ack is high
    always_ff @(posedge clk24) begin
        if (accept) begin
            if (wb_we) begin
                cmd_data <= wb_dat_w;
            end else begin
                wb_dat_r <= rd_mux;
            end
        end
    end

endmodule

// File: design/mcu_link_pkg.sv
package mcu_link_pkg;

    // Command, reply and host data word width
    localparam int word_w = 16;

    // Wishbone word address width
    localparam int addr_w = 2;

    // Host register map

    // Write only register that loads the command and raises the MCU interrupt
    localparam logic [addr_w-1:0] reg_cmd = 2'd0;

    // Read only copy of the last reply written by the MCU
    localparam logic [addr_w-1:0] reg_reply = 2'd1;

    // Read only status flags
    localparam logic [addr_w-1:0] reg_status = 2'd2;

    // Status word bit positions

    // Interrupt still pending at the MCU
    localparam int st_irq_bit = 0;

    // Both reply bytes written since the last command or reply read
    localparam int st_reply_bit = 1;

    // MCU took too long to service the interrupt
    localparam int st_tmo_bit = 2;

endpackage
